// ==== Makefile ====
# Verilator build and run for the RTC bus controller

VERILATOR ?= verilator
TOP       ?= rtcController_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUNARGS   ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUNARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Everything OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
design/rtcPkg.sv
design/rtcBusIf.sv
design/busCycle.sv
design/rtcSequencer.sv
design/timeRegisters.sv
design/rtcController.sv
dv/rtcModel.sv
dv/rtcController_sva.sv
dv/rtcController_tb.sv

// ==== design/busCycle.sv ====
`timescale 1ns/10ps

module busCycle #(
    parameter int StrobeCycles = 12,
    parameter int GapCycles    = 11
) (
    input  logic          dclk,
    input  logic          reset,
    rtcBusIf.engine       bus,
    output logic          ad,
    output logic          rd,
    output logic          wr,
    output logic          cs,
    output logic          busOe,
    output rtcPkg::byte_t busOut,
    input  rtcPkg::byte_t busIn
);
    import rtcPkg::*;

    localparam int MaxLen = (StrobeCycles > GapCycles) ? StrobeCycles : GapCycles;
    localparam int CountW = $clog2(MaxLen + 1);
    localparam logic [CountW-1:0] StrobeLast = CountW'(StrobeCycles - 1);
    localparam logic [CountW-1:0] GapLast    = CountW'(GapCycles - 1);

    // phase encoding
    localparam logic [2:0] PhIdle = 3'd0;
    localparam logic [2:0] PhAddr = 3'd1;
    localparam logic [2:0] PhGap1 = 3'd2;
    localparam logic [2:0] PhData = 3'd3;
    localparam logic [2:0] PhGap2 = 3'd4;

    logic [2:0]        phase;
    logic [CountW-1:0] phaseCount;
    stepKind_t         kindHold;    // kind of the running request
    byte_t             wrHold;
    byte_t             rdHold;
    logic              gapEnd;
    logic              strobeEnd;

    assign gapEnd    = phaseCount == GapLast;
    assign strobeEnd = phaseCount == StrobeLast;

    // a command ends after the first gap, write and read after the second
    assign bus.done   = gapEnd && ((phase == PhGap1 && kindHold == stepCmd) || phase == PhGap2);
    assign bus.rdData = rdHold;

    //////////////////////////////
    // phase FSM and bus outputs
    always_ff @(posedge dclk or posedge reset) begin
        if (reset) begin
            phase      <= PhIdle;
            phaseCount <= '0;
            kindHold   <= stepCmd;
            ad         <= 1'b1;
            rd         <= 1'b1;
            wr         <= 1'b1;
            cs         <= 1'b1;
            busOe      <= 1'b0;
            busOut     <= '0;
        end else begin
            phaseCount <= phaseCount + 1'b1;
            case (phase)
                PhIdle: begin
                    if (bus.start) begin
                        phase      <= PhAddr;
                        phaseCount <= '0;
                        kindHold   <= bus.kind;
                        ad         <= 1'b0;     // address latch strobe
                        cs         <= 1'b0;
                        wr         <= 1'b0;
                        busOe      <= 1'b1;
                        busOut     <= bus.addr;
                    end
                end
                PhAddr: begin
                    if (strobeEnd) begin
                        phase      <= PhGap1;
                        phaseCount <= '0;
                        ad         <= 1'b1;
                        cs         <= 1'b1;
                        wr         <= 1'b1;
                        busOe      <= 1'b0;
                    end
                end
                PhGap1: begin
                    if (gapEnd) begin
                        phaseCount <= '0;
                        if (kindHold == stepCmd) begin
                            phase <= PhIdle;
                        end else begin
                            phase  <= PhData;
                            cs     <= 1'b0;
                            wr     <= kindHold != stepWrite;
                            rd     <= kindHold != stepRead;
                            busOe  <= kindHold == stepWrite; // chip drives on reads
                            busOut <= wrHold;
                        end
                    end
                end
                PhData: begin
                    if (strobeEnd) begin
                        phase      <= PhGap2;
                        phaseCount <= '0;
                        cs         <= 1'b1;
                        wr         <= 1'b1;
                        rd         <= 1'b1;
                        busOe      <= 1'b0;
                    end
                end
                PhGap2: begin
                    if (gapEnd) begin
                        phase <= PhIdle;
                    end
                end
                default: phase <= PhIdle;
            endcase
        end
    end

    // write data held from start, read data taken at the end of the rd strobe
    always_ff @(posedge dclk) begin
        if (phase == PhIdle && bus.start) begin
            wrHold <= bus.wrData;
        end
        if (phase == PhData && strobeEnd && kindHold == stepRead) begin
            rdHold <= busIn;
        end
    end

endmodule

// ==== design/rtcBusIf.sv ====
`timescale 1ns/10ps

interface rtcBusIf;
    import rtcPkg::*;

    // request side
    logic      start;   // one-cycle pulse, engine idle only
    stepKind_t kind;
    byte_t     addr;
    byte_t     wrData;

    // response side
    logic      done;    // last cycle of the request
    byte_t     rdData;  // valid with done on reads

    modport requester (
        output start, kind, addr, wrData,
        input  done, rdData
    );

    modport engine (
        input  start, kind, addr, wrData,
        output done, rdData
    );

endinterface

// ==== design/rtcController.sv ====
`timescale 1ns/10ps

module rtcController #(
    parameter int StrobeCycles = 12,
    parameter int GapCycles    = 11
) (
    input  logic          dclk,
    input  logic          reset,
    input  logic          chronoRun,
    input  rtcPkg::byte_t busIn,
    output logic          ad,
    output logic          rd,
    output logic          wr,
    output logic          cs,
    output logic          busOe,
    output rtcPkg::byte_t busOut,
    output rtcPkg::byte_t day,
    output rtcPkg::byte_t month,
    output rtcPkg::byte_t year,
    output rtcPkg::byte_t hours,
    output rtcPkg::byte_t minutes,
    output rtcPkg::byte_t seconds,
    output rtcPkg::byte_t chronoHours,
    output rtcPkg::byte_t chronoMinutes,
    output rtcPkg::byte_t chronoSeconds,
    output logic          passDone
);
    import rtcPkg::*;

    logic      fieldLoad;
    fieldIdx_t fieldSel;
    byte_t     fieldData;

    rtcBusIf busIf ();

    //////////////////////////////
    // bus side
    busCycle #(
        .StrobeCycles (StrobeCycles),
        .GapCycles    (GapCycles)
    ) busCycle_i (
        .dclk   (dclk),
        .reset  (reset),
        .bus    (busIf.engine),
        .ad     (ad),
        .rd     (rd),
        .wr     (wr),
        .cs     (cs),
        .busOe  (busOe),
        .busOut (busOut),
        .busIn  (busIn)
    );

    rtcSequencer #(
        .GapCycles (GapCycles)
    ) sequencer_i (
        .dclk      (dclk),
        .reset     (reset),
        .chronoRun (chronoRun),
        .bus       (busIf.requester),
        .fieldLoad (fieldLoad),
        .fieldSel  (fieldSel),
        .fieldData (fieldData)
    );

    //////////////////////////////
    // captured clock fields
    timeRegisters timeRegs_i (
        .dclk          (dclk),
        .reset         (reset),
        .fieldLoad     (fieldLoad),
        .fieldSel      (fieldSel),
        .fieldData     (fieldData),
        .day           (day),
        .month         (month),
        .year          (year),
        .hours         (hours),
        .minutes       (minutes),
        .seconds       (seconds),
        .chronoHours   (chronoHours),
        .chronoMinutes (chronoMinutes),
        .chronoSeconds (chronoSeconds),
        .passDone      (passDone)
    );

endmodule

// ==== design/rtcPkg.sv ====
package rtcPkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [1:0] {
        stepCmd,    // address phase only
        stepWrite,
        stepRead
    } stepKind_t;

    typedef logic [3:0] fieldIdx_t;

    // write data for a write step, destination field for a read step
    typedef union packed {
        byte_t wrData;
        struct packed {
            logic [3:0] pad;
            fieldIdx_t  idx;
        } rdField;
    } stepPayload_t;

    typedef struct packed {
        stepKind_t    kind;
        byte_t        addr;
        stepPayload_t payload;
    } step_t;

    //////////////////////////////
    // chip register map
    localparam byte_t addrControl    = 8'h00;
    localparam byte_t addrConfig     = 8'h02;
    localparam byte_t addrTrim       = 8'h16;
    localparam byte_t addrSec        = 8'h21;
    localparam byte_t addrMin        = 8'h22;
    localparam byte_t addrHour       = 8'h23;
    localparam byte_t addrDay        = 8'h24;
    localparam byte_t addrMonth      = 8'h25;
    localparam byte_t addrYear       = 8'h26;
    localparam byte_t addrChronoSec  = 8'h41;
    localparam byte_t addrChronoMin  = 8'h42;
    localparam byte_t addrChronoHour = 8'h43;

    localparam byte_t cmdTransfer  = 8'hF0; // latch time into readable regs
    localparam byte_t configStart  = 8'h10;
    localparam byte_t trimValue    = 8'd45;
    localparam byte_t chronoRunBit = 8'h08;

    //////////////////////////////
    // field indices, in pass order
    localparam int numFields = 9;
    localparam fieldIdx_t fieldDay        = 4'd0;
    localparam fieldIdx_t fieldMonth      = 4'd1;
    localparam fieldIdx_t fieldYear       = 4'd2;
    localparam fieldIdx_t fieldHour       = 4'd3;
    localparam fieldIdx_t fieldMin        = 4'd4;
    localparam fieldIdx_t fieldSec        = 4'd5;
    localparam fieldIdx_t fieldChronoHour = 4'd6;
    localparam fieldIdx_t fieldChronoMin  = 4'd7;
    localparam fieldIdx_t fieldChronoSec  = 4'd8;
    localparam fieldIdx_t fieldDiscard    = 4'd15; // dummy read, never stored

endpackage

// ==== design/rtcSequencer.sv ====
`timescale 1ns/10ps

module rtcSequencer #(
    parameter int GapCycles = 11
) (
    input  logic              dclk,
    input  logic              reset,
    input  logic              chronoRun,
    rtcBusIf.requester        bus,
    output logic              fieldLoad,
    output rtcPkg::fieldIdx_t fieldSel,
    output rtcPkg::byte_t     fieldData
);
    import rtcPkg::*;

    localparam logic [3:0] PassFirst = 4'd4;   // control write of the pass
    localparam logic [3:0] PassLast  = 4'd15;
    localparam int WaitW = $clog2(GapCycles + 1);
    localparam logic [WaitW-1:0] WaitLast = WaitW'(GapCycles - 1);

    logic [3:0]       stepIdx;      // next step to issue
    logic [WaitW-1:0] waitCount;
    logic             powerWait;
    logic             issue;
    step_t            nextStep;
    stepPayload_t     issuePayload;
    stepPayload_t     curPayload;

    function automatic step_t makeStep(input stepKind_t kind, input byte_t addr,
                                       input byte_t data);
        step_t s;
        s.kind           = kind;
        s.addr           = addr;
        s.payload.wrData = data;
        return s;
    endfunction

    function automatic step_t makeRead(input byte_t addr, input fieldIdx_t field);
        step_t s;
        s.kind                = stepRead;
        s.addr                = addr;
        s.payload.rdField.pad = '0;
        s.payload.rdField.idx = field;
        return s;
    endfunction

    //////////////////////////////
    // script ROM
    function automatic step_t scriptStep(input logic [3:0] idx);
        step_t s;
        case (idx)
            4'd0:    s = makeStep(stepWrite, addrConfig, configStart);
            4'd1:    s = makeStep(stepWrite, addrConfig, 8'h00);
            4'd2:    s = makeStep(stepWrite, addrTrim, trimValue);
            4'd3:    s = makeStep(stepWrite, addrControl, 8'h00);
            4'd4:    s = makeStep(stepWrite, addrControl, 8'h00); // run bit patched in
            4'd5:    s = makeStep(stepCmd, cmdTransfer, 8'h00);
            4'd6:    s = makeRead(addrControl, fieldDiscard);
            4'd7:    s = makeRead(addrDay, fieldDay);
            4'd8:    s = makeRead(addrMonth, fieldMonth);
            4'd9:    s = makeRead(addrYear, fieldYear);
            4'd10:   s = makeRead(addrHour, fieldHour);
            4'd11:   s = makeRead(addrMin, fieldMin);
            4'd12:   s = makeRead(addrSec, fieldSec);
            4'd13:   s = makeRead(addrChronoHour, fieldChronoHour);
            4'd14:   s = makeRead(addrChronoMin, fieldChronoMin);
            default: s = makeRead(addrChronoSec, fieldChronoSec);
        endcase
        return s;
    endfunction

    assign nextStep = scriptStep(stepIdx);
    assign issue    = (powerWait && waitCount == WaitLast) || bus.done;

    always_comb begin
        issuePayload = nextStep.payload;
        if (stepIdx == PassFirst) begin
            issuePayload.wrData = chronoRun ? chronoRunBit : 8'h00;
        end
    end

    always_ff @(posedge dclk or posedge reset) begin
        if (reset) begin
            powerWait <= 1'b1;
            waitCount <= '0;
            stepIdx   <= '0;
            bus.start <= 1'b0;
            bus.kind  <= stepCmd;
        end else begin
            bus.start <= issue;     // one cycle after done
            if (powerWait) begin
                waitCount <= waitCount + 1'b1;
            end
            if (issue) begin
                powerWait <= 1'b0;
                bus.kind  <= nextStep.kind;
                stepIdx   <= (stepIdx == PassLast) ? PassFirst : stepIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge dclk) begin
        if (issue) begin
            bus.addr   <= nextStep.addr;
            curPayload <= issuePayload;
        end
    end

    assign bus.wrData = curPayload.wrData;

    // read results go straight out with done
    assign fieldSel  = curPayload.rdField.idx;
    assign fieldData = bus.rdData;
    assign fieldLoad = bus.done && bus.kind == stepRead && fieldSel != fieldDiscard;

endmodule

// ==== design/timeRegisters.sv ====
`timescale 1ns/10ps

module timeRegisters (
    input  logic              dclk,
    input  logic              reset,
    input  logic              fieldLoad,
    input  rtcPkg::fieldIdx_t fieldSel,
    input  rtcPkg::byte_t     fieldData,
    output rtcPkg::byte_t     day,
    output rtcPkg::byte_t     month,
    output rtcPkg::byte_t     year,
    output rtcPkg::byte_t     hours,
    output rtcPkg::byte_t     minutes,
    output rtcPkg::byte_t     seconds,
    output rtcPkg::byte_t     chronoHours,
    output rtcPkg::byte_t     chronoMinutes,
    output rtcPkg::byte_t     chronoSeconds,
    output logic              passDone
);
    import rtcPkg::*;

    byte_t fieldReg [numFields];

    always_ff @(posedge dclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < numFields; i++) begin
                fieldReg[i] <= '0;
            end
            passDone <= 1'b0;
        end else begin
            if (fieldLoad && fieldSel < numFields) begin
                fieldReg[fieldSel] <= fieldData;
            end
            passDone <= fieldLoad && fieldSel == fieldChronoSec; // last read of a pass
        end
    end

    assign day           = fieldReg[fieldDay];
    assign month         = fieldReg[fieldMonth];
    assign year          = fieldReg[fieldYear];
    assign hours         = fieldReg[fieldHour];
    assign minutes       = fieldReg[fieldMin];
    assign seconds       = fieldReg[fieldSec];
    assign chronoHours   = fieldReg[fieldChronoHour];
    assign chronoMinutes = fieldReg[fieldChronoMin];
    assign chronoSeconds = fieldReg[fieldChronoSec];

endmodule

// ==== dv/rtcController_sva.sv ====
`timescale 1ns/10ps

module rtcBusChecks #(
    parameter int StrobeCycles = 12
) (
    input logic dclk,
    input logic reset,
    input logic rd,
    input logic wr,
    input logic cs,
    input logic busOe,
    input logic passDone
);
    int lowCount;       // cycles cs has been low
    int failCount = 0;

    always @(posedge dclk or posedge reset) begin
        if (reset) begin
            lowCount <= 0;
        end else if (!cs) begin
            lowCount <= lowCount + 1;
        end else begin
            lowCount <= 0;
        end
    end

    noRdWrOverlap: assert property (@(posedge dclk) disable iff (reset) !(!rd && !wr))
        else begin
            $error("rd and wr low together");
            failCount++;
        end

    noDriveOnRead: assert property (@(posedge dclk) disable iff (reset) !(busOe && !rd))
        else begin
            $error("busOe high while rd low");
            failCount++;
        end

    //////////////////////////////
    // strobe and pulse widths
    strobeLength: assert property (@(posedge dclk) disable iff (reset)
            $rose(cs) |-> lowCount == StrobeCycles)
        else begin
            $error("cs strobe lasted %0d cycles", lowCount);
            failCount++;
        end

    passPulse: assert property (@(posedge dclk) disable iff (reset) passDone |=> !passDone)
        else begin
            $error("passDone longer than one cycle");
            failCount++;
        end

endmodule

bind rtcController rtcBusChecks #(.StrobeCycles(StrobeCycles)) busChecks_i (
    .dclk     (dclk),
    .reset    (reset),
    .rd       (rd),
    .wr       (wr),
    .cs       (cs),
    .busOe    (busOe),
    .passDone (passDone)
);

// ==== dv/rtcController_tb.sv ====
`timescale 1ns/10ps

module rtcController_tb;
    import rtcPkg::*;

    localparam int InitCycles    = 250;     // power-up wait and init script
    localparam int PassCycles    = 550;     // one read pass, rounded up
    localparam int TimeoutCycles = InitCycles + 7 * PassCycles + 1900;

    logic  dclk;
    logic  reset;
    logic  chronoRun;
    byte_t busIn;
    logic  ad, rd, wr, cs, busOe, passDone;
    byte_t busOut;
    byte_t day, month, year, hours, minutes, seconds;
    byte_t chronoHours, chronoMinutes, chronoSeconds;

    int    errorCount = 0;
    int    assertFails;
    int    cycleCount = 0;
    int    seed = 94;
    byte_t expRegs [256];

    rtcController #(
        .StrobeCycles (12),
        .GapCycles    (11)
    ) dut_i (
        .dclk (dclk), .reset (reset), .chronoRun (chronoRun), .busIn (busIn),
        .ad (ad), .rd (rd), .wr (wr), .cs (cs), .busOe (busOe), .busOut (busOut),
        .day (day), .month (month), .year (year),
        .hours (hours), .minutes (minutes), .seconds (seconds),
        .chronoHours (chronoHours), .chronoMinutes (chronoMinutes),
        .chronoSeconds (chronoSeconds), .passDone (passDone)
    );

    rtcModel model_i (
        .dclk (dclk), .reset (reset), .ad (ad), .rd (rd), .wr (wr), .cs (cs),
        .busOe (busOe), .busOut (busOut), .busIn (busIn)
    );

    always #4 dclk = ~dclk;

    always @(posedge dclk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: tests still running after %0d cycles", cycleCount);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////
    // compare tasks
    task automatic compareBit(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: expected %b, got %b", testName, expected, actual);
        end
    endtask

    task automatic compareByte(input string testName, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: expected %h, got %h", testName, expected, actual);
        end
    endtask

    task automatic compareStep(input string testName, input byte_t expAddr, input byte_t expData,
                               input byte_t actAddr, input byte_t actData);
        if (actAddr !== expAddr || actData !== expData) begin
            errorCount++;
            $display("error %s: expected %h<-%h, got %h<-%h",
                     testName, expAddr, expData, actAddr, actData);
        end
    endtask

    //////////////////////////////
    // helpers
    task automatic tick();
        @(posedge dclk);
        #1;     // drive and sample point
    endtask

    task automatic waitPassDone();
        do begin
            tick();
        end while (passDone !== 1'b1);
    endtask

    task automatic loadRandomRegs();
        int rnd;
        for (int a = 0; a < 256; a++) begin
            rnd = $random(seed);
            expRegs[a] = rnd[7:0];
            model_i.loadReg(a[7:0], rnd[7:0]);
        end
    endtask

    function automatic byte_t expectedAt(input byte_t a, input bit expectZero);
        return expectZero ? 8'h00 : expRegs[a];
    endfunction

    task automatic checkFields(input string testName, input bit expectZero);
        compareByte(testName, expectedAt(addrDay, expectZero), day);
        compareByte(testName, expectedAt(addrMonth, expectZero), month);
        compareByte(testName, expectedAt(addrYear, expectZero), year);
        compareByte(testName, expectedAt(addrHour, expectZero), hours);
        compareByte(testName, expectedAt(addrMin, expectZero), minutes);
        compareByte(testName, expectedAt(addrSec, expectZero), seconds);
        compareByte(testName, expectedAt(addrChronoHour, expectZero), chronoHours);
        compareByte(testName, expectedAt(addrChronoMin, expectZero), chronoMinutes);
        compareByte(testName, expectedAt(addrChronoSec, expectZero), chronoSeconds);
    endtask

    task automatic checkIdle(input string testName);
        compareBit(testName, 1'b1, ad);
        compareBit(testName, 1'b1, rd);
        compareBit(testName, 1'b1, wr);
        compareBit(testName, 1'b1, cs);
        compareBit(testName, 1'b0, busOe);
        compareBit(testName, 1'b0, passDone);
        checkFields(testName, 1'b1);
    endtask

    task automatic checkLogEntry(input string testName, input int idx,
                                 input byte_t expAddr, input byte_t expData);
        logic [15:0] entry;
        entry = model_i.logEntry(idx);
        compareStep(testName, expAddr, expData, entry[15:8], entry[7:0]);
    endtask

    // last control register write logged since fromIdx
    task automatic checkControlWrite(input string testName, input int fromIdx,
                                     input byte_t expData);
        logic [15:0] entry;
        logic [15:0] last;
        bit          found;
        found = 1'b0;
        last  = '0;
        for (int i = fromIdx; i < model_i.logSize(); i++) begin
            entry = model_i.logEntry(i);
            if (entry[15:8] == 8'h00) begin
                found = 1'b1;
                last  = entry;
            end
        end
        if (!found) begin
            errorCount++;
            $display("%s: no write to the control register was logged", testName);
        end else begin
            compareStep(testName, 8'h00, expData, last[15:8], last[7:0]);
        end
    endtask

    //////////////////////////////
    // directed tests
    task automatic resetState();
        repeat (2) tick();
        checkIdle("resetState");
        repeat (2) tick();
        reset = 1'b0;
        tick();
        checkIdle("resetState");
    endtask

    task automatic initScript();
        while (model_i.logSize() < 6) begin
            tick();
        end
        checkLogEntry("initScript", 0, 8'h02, 8'h10);
        checkLogEntry("initScript", 1, 8'h02, 8'h00);
        checkLogEntry("initScript", 2, 8'h16, 8'd45);
        checkLogEntry("initScript", 3, 8'h00, 8'h00);
        checkLogEntry("initScript", 4, 8'h00, 8'h00);   // first pass, chronoRun low
        checkLogEntry("initScript", 5, 8'hF0, 8'h00);   // transfer command
    endtask

    task automatic fieldReadback();
        waitPassDone();
        checkFields("fieldReadback", 1'b0);
    endtask

    task automatic fieldUpdate();
        repeat (200) tick();    // change contents mid pass
        loadRandomRegs();
        waitPassDone();
        waitPassDone();
        checkFields("fieldUpdate", 1'b0);
    endtask

    task automatic chronoControl();
        int mark;
        chronoRun = 1'b1;
        mark = model_i.logSize();
        waitPassDone();
        waitPassDone();
        checkControlWrite("chronoControl", mark, 8'h08);
        chronoRun = 1'b0;
        mark = model_i.logSize();
        waitPassDone();
        waitPassDone();
        checkControlWrite("chronoControl", mark, 8'h00);
    endtask

    initial begin
        dclk      = 1'b0;
        reset     = 1'b1;
        chronoRun = 1'b0;
        loadRandomRegs();

        resetState();
        initScript();
        fieldReadback();
        fieldUpdate();
        chronoControl();

        assertFails = dut_i.busChecks_i.failCount;
        $display("errors: %0d check, %0d assertion", errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/rtcModel.sv ====
`timescale 1ns/10ps

module rtcModel (
    input  logic          dclk,
    input  logic          reset,
    input  logic          ad,
    input  logic          rd,
    input  logic          wr,
    input  logic          cs,
    input  logic          busOe,
    input  rtcPkg::byte_t busOut,
    output rtcPkg::byte_t busIn
);
    import rtcPkg::*;

    byte_t       regs [256];
    byte_t       curAddr;       // address of the last address phase
    logic        cmdPending;    // address phase seen, no data phase yet
    logic        inStrobe;
    logic [15:0] writeLog [$];  // {addr, data}, commands carry data 0

    // chip drives the bus while rd is low
    assign busIn = rd ? 8'h00 : regs[curAddr];

    //////////////////////////////
    // strobe decode
    always @(posedge dclk or posedge reset) begin
        if (reset) begin
            curAddr    <= 8'h00;
            cmdPending <= 1'b0;
            inStrobe   <= 1'b0;
        end else if (cs) begin
            inStrobe <= 1'b0;
        end else if (!inStrobe) begin
            inStrobe <= 1'b1;   // first cycle of a cs strobe
            if (!ad) begin
                // two address phases in a row, so the first was a command
                if (cmdPending) begin
                    writeLog.push_back({curAddr, 8'h00});
                end
                curAddr    <= busOut;
                cmdPending <= 1'b1;
            end else begin
                cmdPending <= 1'b0;
                if (!wr && busOe) begin
                    writeLog.push_back({curAddr, busOut});
                end
            end
        end
    end

    task automatic loadReg(input byte_t a, input byte_t d);
        regs[a] = d;
    endtask

    function automatic int logSize();
        return writeLog.size();
    endfunction

    function automatic logic [15:0] logEntry(input int idx);
        return writeLog[idx];
    endfunction

endmodule
